// ==== src.f ====
source/fetchPkg.sv
source/preDecode.sv
source/ctiQueue.sv
source/branchValidate.sv
source/fetchStage2.sv
testbench/clockGen.sv
testbench/fetchStage2Tb.sv

// ==== Makefile ====
# Verilator build and run of the fetch stage 2 testbench
VERILATOR ?= verilator
TOP       ?= fetchStage2Tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -Wno-fatal
PASS_MSG  ?= All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== testbench/fetchStage2Tb.sv ====
/*
 * Table-driven testbench for fetch stage 2. Each row is one bundle with
 * its BTB slots, execute and commit pulses and the expected outputs.
 * Rows are applied one per cycle, combinational outputs are checked at
 * the falling edge and commit updates one cycle after the pulse.
 */
`timescale 1ns/1ps
`default_nettype none

module fetchStage2Tb;
  import fetchPkg::*;

  localparam pc_t RAS_ADDR = 32'h0000_5000;

  typedef struct packed {
    pc_t                         pc;
    inst_t [FETCH_WIDTH-1:0]     inst;
    btbSlot_t [FETCH_WIDTH-1:0]  btb;
    logic                        stall;
    logic                        recover;
    logic                        verify;
    logic                        recoverEx;
    logic                        outcome;
    logic                        commit;
    logic                        notReady;
    ctiTag_t                     index;
    pc_t                         resolveTarget;
    slotMask_t                   expValid;
    slotMask_t                   expAlloc;
    ctiTag_t                     expTail;
    logic                        expRedirect;
    logic                        expRtr;
    logic                        expCall;
    pc_t                         expTarget;
    pc_t                         expCallPc;
    logic                        expFull;
    ctiUpdate_t                  expUpdate;
  } row_t;

  logic clk;
  logic rstN;

  pc_t                           pc;
  inst_t [FETCH_WIDTH-1:0]       instBundle;
  btbSlot_t [FETCH_WIDTH-1:0]    btb;
  pc_t                           addrRas;
  logic                          fs1Ready;
  logic                          stall;
  logic                          recoverFlag;
  ctiTag_t                       ctiqIndex;
  pc_t                           resolveTarget;
  logic                          branchOutcome;
  logic                          ctrlVerified;
  logic                          flagRecoverEx;
  logic                          commitCti;
  instPacket_t [FETCH_WIDTH-1:0] packet;
  slotMask_t                     instValid;
  logic                          flagRecoverId;
  pc_t                           targetId;
  logic                          flagRtr;
  logic                          flagCall;
  pc_t                           callPc;
  ctiUpdate_t                    update;
  logic                          updateEn;
  logic                          fs2Ready;
  logic                          ctiQueueFull;

  row_t rows[$];
  row_t cur;
  row_t prev;
  int   errors = 0;
  int   checks = 0;
  int   cycles = 0;
  int   cycleLimit = 1000;

  clockGen clk0 (
    .clk_o  (clk),
    .rstN_o (rstN)
  );

  fetchStage2 dut0 (
    .clk             (clk),
    .rstN_i          (rstN),
    .pc_i            (pc),
    .instBundle_i    (instBundle),
    .btb_i           (btb),
    .addrRas_i       (addrRas),
    .fs1Ready_i      (fs1Ready),
    .stall_i         (stall),
    .recoverFlag_i   (recoverFlag),
    .ctiqIndex_i     (ctiqIndex),
    .resolveTarget_i (resolveTarget),
    .branchOutcome_i (branchOutcome),
    .ctrlVerified_i  (ctrlVerified),
    .flagRecoverEx_i (flagRecoverEx),
    .commitCti_i     (commitCti),
    .packet_o        (packet),
    .instValid_o     (instValid),
    .flagRecoverId_o (flagRecoverId),
    .targetId_o      (targetId),
    .flagRtr_o       (flagRtr),
    .flagCall_o      (flagCall),
    .callPc_o        (callPc),
    .update_o        (update),
    .updateEn_o      (updateEn),
    .fs2Ready_o      (fs2Ready),
    .ctiQueueFull_o  (ctiQueueFull)
  );

  function automatic inst_t makeInst(opcode_t op, logic [25:0] field);
    return {op, 30'd0, field};
  endfunction

  // opcodes 0x40 to 0x7f are never control transfers
  function automatic inst_t randomAluWord();
    opcode_t op;
    op = 8'h40 | opcode_t'($urandom % 64);
    return {op, 24'($urandom), 32'($urandom)};
  endfunction

  function automatic ctiUpdate_t makeUpdate(pc_t upPc, pc_t target, ctrlType_t kind,
                                            logic taken);
    ctiUpdate_t upd;
    upd.pc       = upPc;
    upd.target   = target;
    upd.ctrlType = kind;
    upd.taken    = taken;
    return upd;
  endfunction

  // target a packet should carry, from the instruction format rules
  function automatic pc_t expectedTarget(pc_t slotPc, inst_t word, logic hit);
    int  offset;
    pc_t target;
    offset = int'($signed(word[15:0]));
    target = '0;
    case (word[63:56])
      OP_J, OP_JAL: target = pc_t'(word[25:0]) * 32'd8;
      OP_BEQ, OP_BNE: target = slotPc + 32'd8 + pc_t'(offset * 8);
      OP_JR: target = hit ? '0 : RAS_ADDR;
      default: target = '0;
    endcase
    return target;
  endfunction

  task automatic newRow(pc_t startPc, ctiTag_t tail);
    cur = '0;
    cur.pc = startPc;
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      cur.inst[s] = randomAluWord();
    end
    cur.expValid = '1;
    cur.expTail  = tail;
  endtask

  task automatic putCti(int slot, inst_t word, logic hit, logic pred);
    cur.inst[slot]           = word;
    cur.btb[slot].hit        = hit;
    cur.btb[slot].prediction = pred;
    cur.btb[slot].target     = expectedTarget(cur.pc + pc_t'(slot * 8), word, 1'b1);
  endtask

  task automatic expectSlots(slotMask_t valid, slotMask_t alloc);
    cur.expValid = valid;
    cur.expAlloc = alloc;
  endtask

  task automatic expectRedirect(pc_t target);
    cur.expRedirect = 1'b1;
    cur.expTarget   = target;
  endtask

  task automatic resolve(ctiTag_t index, pc_t target, logic taken);
    cur.verify        = 1'b1;
    cur.index         = index;
    cur.resolveTarget = target;
    cur.outcome       = taken;
  endtask

  task automatic commitWith(ctiUpdate_t upd);
    cur.commit    = 1'b1;
    cur.expUpdate = upd;
  endtask

  task automatic addRow();
    rows.push_back(cur);
  endtask

  // four not-taken conditional branches that are all recorded
  task automatic condBundle(pc_t startPc, ctiTag_t tail);
    newRow(startPc, tail);
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      putCti(s, makeInst(OP_BEQ, 26'h0), 1'b1, 1'b0);
    end
    expectSlots(4'b1111, 4'b1111);
    addRow();
  endtask

  task automatic buildTable();
    newRow(32'h0000_1000, 4'd0);
    addRow();
    // jump in slot 1 that misses and then hits in the BTB
    newRow(32'h0000_2000, 4'd0);
    putCti(1, makeInst(OP_J, 26'h123), 1'b0, 1'b0);
    expectSlots(4'b0011, 4'b0010);
    expectRedirect(32'h0000_0918);
    addRow();
    newRow(32'h0000_2000, 4'd1);
    putCti(1, makeInst(OP_J, 26'h123), 1'b1, 1'b1);
    expectSlots(4'b0011, 4'b0010);
    addRow();
    newRow(32'h0000_3000, 4'd2);
    putCti(2, makeInst(OP_JR, 26'h0), 1'b0, 1'b0);
    expectSlots(4'b0111, 4'b0100);
    expectRedirect(RAS_ADDR);
    cur.expRtr = 1'b1;
    addRow();
    newRow(32'h0000_4000, 4'd3);
    putCti(1, makeInst(OP_JAL, 26'h40), 1'b0, 1'b0);
    expectSlots(4'b0011, 4'b0010);
    expectRedirect(32'h0000_0200);
    cur.expCall   = 1'b1;
    cur.expCallPc = 32'h0000_4008;
    addRow();
    // flush so the tag tests start from an empty queue
    newRow(32'h0000_1100, 4'd4);
    cur.recover = 1'b1;
    addRow();
    newRow(32'h0000_6000, 4'd0);
    putCti(0, makeInst(OP_BEQ, 26'h0004), 1'b1, 1'b0);
    putCti(2, makeInst(OP_BNE, 26'h000_FFFE), 1'b1, 1'b1);
    expectSlots(4'b0111, 4'b0101);
    addRow();
    newRow(32'h0000_7000, 4'd2);
    putCti(0, makeInst(OP_J, 26'h10), 1'b0, 1'b0);
    expectSlots(4'b0001, 4'b0001);
    cur.stall = 1'b1;
    addRow();
    newRow(32'h0000_8000, 4'd2);
    putCti(3, makeInst(OP_J, 26'h20), 1'b1, 1'b1);
    expectSlots(4'b1111, 4'b1000);
    addRow();
    // resolve entries 0 to 2 and commit them in order
    newRow(32'h0000_1200, 4'd3);
    resolve(4'd0, 32'h0000_6028, 1'b0);
    addRow();
    newRow(32'h0000_1220, 4'd3);
    resolve(4'd1, 32'h0000_6008, 1'b1);
    commitWith(makeUpdate(32'h0000_6000, 32'h0000_6028, ctrlCond, 1'b0));
    addRow();
    newRow(32'h0000_1240, 4'd3);
    resolve(4'd2, 32'h0000_0100, 1'b1);
    commitWith(makeUpdate(32'h0000_6010, 32'h0000_6008, ctrlCond, 1'b1));
    addRow();
    newRow(32'h0000_1260, 4'd3);
    commitWith(makeUpdate(32'h0000_8018, 32'h0000_0100, ctrlJump, 1'b1));
    addRow();
    condBundle(32'h0000_9000, 4'd3);
    // mispredict at entry 4 rolls the tail back to 5
    newRow(32'h0000_1280, 4'd7);
    resolve(4'd4, 32'h0000_1234, 1'b1);
    cur.recoverEx = 1'b1;
    addRow();
    newRow(32'h0000_a000, 4'd5);
    putCti(0, makeInst(OP_J, 26'h1), 1'b1, 1'b1);
    expectSlots(4'b0001, 4'b0001);
    addRow();
    condBundle(32'h0000_9000, 4'd6);
    condBundle(32'h0000_9000, 4'd10);
    condBundle(32'h0000_9000, 4'd14);
    // 15 entries held so the queue is full
    newRow(32'h0000_b000, 4'd2);
    putCti(0, makeInst(OP_J, 26'h2), 1'b0, 1'b0);
    expectSlots(4'b0001, 4'b0001);
    cur.expFull = 1'b1;
    addRow();
    newRow(32'h0000_12a0, 4'd2);
    cur.recover = 1'b1;
    cur.expFull = 1'b1;
    addRow();
    newRow(32'h0000_c000, 4'd3);
    putCti(0, makeInst(OP_J, 26'h3), 1'b1, 1'b1);
    expectSlots(4'b0001, 4'b0001);
    addRow();
    // fetch stage 1 not ready holds the tail
    newRow(32'h0000_d000, 4'd4);
    putCti(0, makeInst(OP_J, 26'h4), 1'b1, 1'b1);
    expectSlots(4'b0001, 4'b0001);
    cur.notReady = 1'b1;
    addRow();
    newRow(32'h0000_e000, 4'd4);
    putCti(0, makeInst(OP_J, 26'h5), 1'b1, 1'b1);
    expectSlots(4'b0001, 4'b0001);
    addRow();
  endtask

  task automatic checkMask(string name, slotMask_t got, slotMask_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic checkPacket(string name, instPacket_t got, instPacket_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkPc(string name, pc_t got, pc_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkBit(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic checkUpdate(string name, ctiUpdate_t got, ctiUpdate_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic applyRow(row_t r);
    pc              <= r.pc;
    instBundle      <= r.inst;
    btb             <= r.btb;
    fs1Ready        <= ~r.notReady;
    stall           <= r.stall;
    recoverFlag     <= r.recover;
    ctrlVerified    <= r.verify;
    flagRecoverEx   <= r.recoverEx;
    branchOutcome   <= r.outcome;
    ctiqIndex       <= r.index;
    resolveTarget   <= r.resolveTarget;
    commitCti       <= r.commit;
  endtask

  task automatic checkRow(row_t r);
    instPacket_t expPkt;
    ctiTag_t     tag;
    pc_t         slotPc;
    tag = r.expTail;
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      slotPc             = r.pc + pc_t'(8 * s);
      expPkt.instruction = r.inst[s];
      expPkt.pc          = slotPc;
      expPkt.target      = expectedTarget(slotPc, r.inst[s], r.btb[s].hit);
      expPkt.ctiqTag     = tag;
      expPkt.prediction  = r.btb[s].prediction;
      checkPacket($sformatf("packet_o[%0d]", s), packet[s], expPkt);
      tag = tag + ctiTag_t'(r.expAlloc[s]);
    end
    checkMask("instValid_o", instValid, r.expValid);
    checkBit("flagRecoverId_o", flagRecoverId, r.expRedirect);
    checkBit("flagRtr_o", flagRtr, r.expRtr);
    checkBit("flagCall_o", flagCall, r.expCall);
    checkBit("ctiQueueFull_o", ctiQueueFull, r.expFull);
    checkBit("fs2Ready_o", fs2Ready, ~r.expFull & ~r.notReady);
    if (r.expRedirect) begin
      checkPc("targetId_o", targetId, r.expTarget);
    end
    if (r.expCall) begin
      checkPc("callPc_o", callPc, r.expCallPc);
    end
  endtask

  // the update from a commit shows one cycle after its pulse
  task automatic checkCommit(row_t r);
    checkBit("updateEn_o", updateEn, r.commit);
    if (r.commit) begin
      checkUpdate("update_o", update, r.expUpdate);
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("timeout after %0d cycles before the table was finished", cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(32));
    buildTable();
    cycleLimit = rows.size() * 4 + 50;
    pc            <= '0;
    instBundle    <= '0;
    btb           <= '0;
    addrRas       <= RAS_ADDR;
    fs1Ready      <= 1'b1;
    stall         <= 1'b0;
    recoverFlag   <= 1'b0;
    ctiqIndex     <= '0;
    resolveTarget <= '0;
    branchOutcome <= 1'b0;
    ctrlVerified  <= 1'b0;
    flagRecoverEx <= 1'b0;
    commitCti     <= 1'b0;
    prev = '0;
    wait (rstN === 1'b1);
    for (int i = 0; i < rows.size(); i++) begin
      @(posedge clk);
      applyRow(rows[i]);
      @(negedge clk);
      checkRow(rows[i]);
      checkCommit(prev);
      prev = rows[i];
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/clockGen.sv ====
/*
 * Clock and active-low reset for the fetch stage 2 testbench.
 * 8 ns period, reset held for the first 10 rising edges.
 */
`timescale 1ns/1ps
`default_nettype none

module clockGen (
  output logic clk_o,
  output logic rstN_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial begin
    rstN_o = 1'b0;
    repeat (10) @(posedge clk_o);
    rstN_o <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== source/fetchStage2.sv ====
/*
 * Second fetch stage of the four-wide front end. Predecodes the
 * bundle, validates the BTB, filters slots, raises early redirects
 * and keeps the CTI queue that feeds BTB and predictor updates.
 */
`timescale 1ns/1ps
`default_nettype none

module fetchStage2 (
  input  wire                                               clk,
  input  wire                                               rstN_i,
  input  fetchPkg::pc_t                                     pc_i,
  input  fetchPkg::inst_t [fetchPkg::FETCH_WIDTH-1:0]       instBundle_i,
  input  fetchPkg::btbSlot_t [fetchPkg::FETCH_WIDTH-1:0]    btb_i,
  input  fetchPkg::pc_t                                     addrRas_i,
  input  wire                                               fs1Ready_i,
  input  wire                                               stall_i,
  input  wire                                               recoverFlag_i,
  input  fetchPkg::ctiTag_t                                 ctiqIndex_i,
  input  fetchPkg::pc_t                                     resolveTarget_i,
  input  wire                                               branchOutcome_i,
  input  wire                                               ctrlVerified_i,
  input  wire                                               flagRecoverEx_i,
  input  wire                                               commitCti_i,
  output fetchPkg::instPacket_t [fetchPkg::FETCH_WIDTH-1:0] packet_o,
  output fetchPkg::slotMask_t                               instValid_o,
  output logic                                              flagRecoverId_o,
  output fetchPkg::pc_t                                     targetId_o,
  output logic                                              flagRtr_o,
  output logic                                              flagCall_o,
  output fetchPkg::pc_t                                     callPc_o,
  output fetchPkg::ctiUpdate_t                              update_o,
  output logic                                              updateEn_o,
  output logic                                              fs2Ready_o,
  output logic                                              ctiQueueFull_o
);
  import fetchPkg::*;

  preDec_t   [FETCH_WIDTH-1:0] preDec;
  pc_t       [FETCH_WIDTH-1:0] slotPc;
  ctrlType_t [FETCH_WIDTH-1:0] slotType;
  slotMask_t                   allocMask;
  ctiTag_t                     ctiqTail;

  for (genvar s = 0; s < FETCH_WIDTH; s++) begin : slotGen
    preDecode preDecodeInst (
      .pc_i     (slotPc[s]),
      .inst_i   (instBundle_i[s]),
      .preDec_o (preDec[s])
    );
  end

  ctiQueue ctiQueue0 (
    .clk             (clk),
    .rstN_i          (rstN_i),
    .fs1Ready_i      (fs1Ready_i),
    .stall_i         (stall_i),
    .recoverFlag_i   (recoverFlag_i),
    .allocMask_i     (allocMask),
    .slotPc_i        (slotPc),
    .slotType_i      (slotType),
    .ctiqIndex_i     (ctiqIndex_i),
    .resolveTarget_i (resolveTarget_i),
    .branchOutcome_i (branchOutcome_i),
    .ctrlVerified_i  (ctrlVerified_i),
    .flagRecoverEx_i (flagRecoverEx_i),
    .commitCti_i     (commitCti_i),
    .ctiqTail_o      (ctiqTail),
    .ctiQueueFull_o  (ctiQueueFull_o),
    .update_o        (update_o),
    .updateEn_o      (updateEn_o)
  );

  branchValidate branchValidate0 (
    .pc_i            (pc_i),
    .instBundle_i    (instBundle_i),
    .preDec_i        (preDec),
    .btb_i           (btb_i),
    .addrRas_i       (addrRas_i),
    .stall_i         (stall_i),
    .ctiQueueFull_i  (ctiQueueFull_o),
    .ctiqTail_i      (ctiqTail),
    .allocMask_o     (allocMask),
    .slotPc_o        (slotPc),
    .slotType_o      (slotType),
    .packet_o        (packet_o),
    .instValid_o     (instValid_o),
    .flagRecoverId_o (flagRecoverId_o),
    .targetId_o      (targetId_o),
    .flagRtr_o       (flagRtr_o),
    .flagCall_o      (flagCall_o),
    .callPc_o        (callPc_o)
  );

  assign fs2Ready_o = fs1Ready_i & ~ctiQueueFull_o;

endmodule

`default_nettype wire

// ==== source/branchValidate.sv ====
/*
 * Checks the BTB against the predecoded slots of a bundle. Finds the
 * first taken control transfer, filters the slots after it, picks the
 * slots to record in the CTI queue, raises the early redirect on a BTB
 * miss and assembles the instruction packets.
 */
`timescale 1ns/1ps
`default_nettype none

module branchValidate (
  input  fetchPkg::pc_t                                     pc_i,
  input  fetchPkg::inst_t [fetchPkg::FETCH_WIDTH-1:0]       instBundle_i,
  input  fetchPkg::preDec_t [fetchPkg::FETCH_WIDTH-1:0]     preDec_i,
  input  fetchPkg::btbSlot_t [fetchPkg::FETCH_WIDTH-1:0]    btb_i,
  input  fetchPkg::pc_t                                     addrRas_i,
  input  wire                                               stall_i,
  input  wire                                               ctiQueueFull_i,
  input  fetchPkg::ctiTag_t                                 ctiqTail_i,
  output fetchPkg::slotMask_t                               allocMask_o,
  output fetchPkg::pc_t [fetchPkg::FETCH_WIDTH-1:0]         slotPc_o,
  output fetchPkg::ctrlType_t [fetchPkg::FETCH_WIDTH-1:0]   slotType_o,
  output fetchPkg::instPacket_t [fetchPkg::FETCH_WIDTH-1:0] packet_o,
  output fetchPkg::slotMask_t                               instValid_o,
  output logic                                              flagRecoverId_o,
  output fetchPkg::pc_t                                     targetId_o,
  output logic                                              flagRtr_o,
  output logic                                              flagCall_o,
  output fetchPkg::pc_t                                     callPc_o
);
  import fetchPkg::*;

  slotMask_t takenCtrl;
  slotMask_t notTakenCond;
  logic      found;
  slotIdx_t  firstSlot;
  logic      flagRecover;
  ctiTag_t   tagOffset;

  always_comb begin
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      slotPc_o[s]     = pc_i + pc_t'(s) * pc_t'(INST_BYTES);
      slotType_o[s]   = preDec_i[s].ctrlType;
      takenCtrl[s]    = preDec_i[s].isCtrl &
                        (btb_i[s].prediction | (preDec_i[s].ctrlType != ctrlCond));
      notTakenCond[s] = preDec_i[s].isCtrl & ~btb_i[s].prediction &
                        (preDec_i[s].ctrlType == ctrlCond);
    end
  end

  // priority search from slot 0
  always_comb begin
    found     = 1'b0;
    firstSlot = '0;
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      if (takenCtrl[s] && !found) begin
        found     = 1'b1;
        firstSlot = slotIdx_t'(s);
      end
    end
  end

  always_comb begin
    instValid_o = '1;
    allocMask_o = notTakenCond;
    if (found) begin
      for (int s = 0; s < FETCH_WIDTH; s++) begin
        instValid_o[s] = (s <= int'(firstSlot));
        allocMask_o[s] = (s < int'(firstSlot)) ? notTakenCond[s] : (s == int'(firstSlot));
      end
    end
  end

  always_comb begin
    flagRecover = found & ~btb_i[firstSlot].hit;
    flagRtr_o   = flagRecover & (preDec_i[firstSlot].ctrlType == ctrlReturn);
    flagCall_o  = flagRecover & (preDec_i[firstSlot].ctrlType == ctrlCall);
    callPc_o    = slotPc_o[firstSlot];
    targetId_o  = '0;
    if (found) begin
      targetId_o = (preDec_i[firstSlot].ctrlType == ctrlReturn) ?
                   addrRas_i : preDec_i[firstSlot].target;
    end
  end

  assign flagRecoverId_o = flagRecover & ~stall_i & ~ctiQueueFull_i;

  // tags count the allocated slots below each slot
  always_comb begin
    tagOffset = '0;
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      packet_o[s].instruction = instBundle_i[s];
      packet_o[s].pc          = slotPc_o[s];
      packet_o[s].target      = preDec_i[s].target;
      if (preDec_i[s].isCtrl && (preDec_i[s].ctrlType == ctrlReturn) && !btb_i[s].hit) begin
        packet_o[s].target = addrRas_i;
      end
      packet_o[s].ctiqTag    = ctiqTail_i + tagOffset;
      packet_o[s].prediction = btb_i[s].prediction;
      tagOffset              = tagOffset + ctiTag_t'(allocMask_o[s]);
    end
  end

endmodule

`default_nettype wire

// ==== source/ctiQueue.sv ====
/*
 * Circular queue of the control transfers kept by fetch stage 2.
 * Allocates the masked slots of a bundle at consecutive indices, takes
 * resolved targets and outcomes from execute, rolls back on a
 * mispredict, flushes on recovery and turns each commit into one
 * registered BTB update.
 */
`timescale 1ns/1ps
`default_nettype none

module ctiQueue (
  input  wire                                             clk,
  input  wire                                             rstN_i,
  input  wire                                             fs1Ready_i,
  input  wire                                             stall_i,
  input  wire                                             recoverFlag_i,
  input  fetchPkg::slotMask_t                             allocMask_i,
  input  fetchPkg::pc_t [fetchPkg::FETCH_WIDTH-1:0]       slotPc_i,
  input  fetchPkg::ctrlType_t [fetchPkg::FETCH_WIDTH-1:0] slotType_i,
  input  fetchPkg::ctiTag_t                               ctiqIndex_i,
  input  fetchPkg::pc_t                                   resolveTarget_i,
  input  wire                                             branchOutcome_i,
  input  wire                                             ctrlVerified_i,
  input  wire                                             flagRecoverEx_i,
  input  wire                                             commitCti_i,
  output fetchPkg::ctiTag_t                               ctiqTail_o,
  output logic                                            ctiQueueFull_o,
  output fetchPkg::ctiUpdate_t                            update_o,
  output logic                                            updateEn_o
);
  import fetchPkg::*;

  // index plus one wrap bit
  typedef logic [CTIQ_LOG:0] ptr_t;

  ptr_t      head;
  ptr_t      tail;
  ptr_t      headNext;
  ptr_t      count;
  ptr_t      allocCount;
  ptr_t      rollbackTail;
  ctiTag_t   slotIndex [FETCH_WIDTH];
  logic      allocEn;
  logic      commitEn;

  pc_t       pcMem      [CTIQ_DEPTH];
  ctrlType_t typeMem    [CTIQ_DEPTH];
  pc_t       targetMem  [CTIQ_DEPTH];
  logic      outcomeMem [CTIQ_DEPTH];

  assign count          = tail - head;
  assign ctiQueueFull_o = count > ptr_t'(CTIQ_DEPTH - FETCH_WIDTH);
  assign ctiqTail_o     = tail[CTIQ_LOG-1:0];

  assign allocEn  = fs1Ready_i & ~stall_i & ~ctiQueueFull_o;
  assign commitEn = commitCti_i & (count != '0);
  assign headNext = commitEn ? head + ptr_t'(1) : head;

  // distance from head keeps the wrap bit right after rollback
  assign rollbackTail = head + ptr_t'(ctiTag_t'(ctiqIndex_i - head[CTIQ_LOG-1:0])) + ptr_t'(1);

  // compact masked slots onto consecutive entries
  always_comb begin
    allocCount = '0;
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      slotIndex[s] = tail[CTIQ_LOG-1:0] + allocCount[CTIQ_LOG-1:0];
      allocCount   = allocCount + ptr_t'(allocMask_i[s]);
    end
  end

  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      head       <= '0;
      tail       <= '0;
      updateEn_o <= 1'b0;
    end else begin
      head       <= headNext;
      updateEn_o <= commitEn;
      if (recoverFlag_i) begin
        tail <= headNext;
      end else if (ctrlVerified_i && flagRecoverEx_i) begin
        tail <= rollbackTail;
      end else if (allocEn) begin
        tail <= tail + allocCount;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (allocEn) begin
      for (int s = 0; s < FETCH_WIDTH; s++) begin
        if (allocMask_i[s]) begin
          pcMem[slotIndex[s]]      <= slotPc_i[s];
          typeMem[slotIndex[s]]    <= slotType_i[s];
          targetMem[slotIndex[s]]  <= '0;
          // unconditional transfers are always taken
          outcomeMem[slotIndex[s]] <= (slotType_i[s] != ctrlCond);
        end
      end
    end
    if (ctrlVerified_i) begin
      targetMem[ctiqIndex_i]  <= resolveTarget_i;
      outcomeMem[ctiqIndex_i] <= branchOutcome_i;
    end
  end

  always_ff @(posedge clk) begin
    if (commitEn) begin
      update_o.pc       <= pcMem[head[CTIQ_LOG-1:0]];
      update_o.target   <= targetMem[head[CTIQ_LOG-1:0]];
      update_o.ctrlType <= typeMem[head[CTIQ_LOG-1:0]];
      update_o.taken    <= outcomeMem[head[CTIQ_LOG-1:0]];
    end
  end

endmodule

`default_nettype wire

// ==== source/preDecode.sv ====
/*
 * Predecode of one fetch slot. Finds whether the word is a control
 * transfer, which kind, and its direct target. Purely combinational,
 * one instance per slot of the bundle.
 */
`timescale 1ns/1ps
`default_nettype none

module preDecode (
  input  fetchPkg::pc_t     pc_i,
  input  fetchPkg::inst_t   inst_i,
  output fetchPkg::preDec_t preDec_o
);
  import fetchPkg::*;

  opcode_t opcode;
  pc_t     jumpTarget;
  pc_t     branchTarget;

  assign opcode = inst_i[63:56];

  // index field is in words of 8 bytes
  assign jumpTarget   = {3'b000, inst_i[25:0], 3'b000};
  assign branchTarget = pc_i + pc_t'(INST_BYTES) + {{13{inst_i[15]}}, inst_i[15:0], 3'b000};

  always_comb begin
    preDec_o.isCtrl   = 1'b1;
    preDec_o.ctrlType = ctrlJump;
    preDec_o.target   = '0;
    case (opcode)
      OP_J: begin
        preDec_o.target = jumpTarget;
      end
      OP_JAL: begin
        preDec_o.ctrlType = ctrlCall;
        preDec_o.target   = jumpTarget;
      end
      OP_BEQ, OP_BNE: begin
        preDec_o.ctrlType = ctrlCond;
        preDec_o.target   = branchTarget;
      end
      // return target comes from the RAS later
      OP_JR: begin
        preDec_o.ctrlType = ctrlReturn;
      end
      default: begin
        preDec_o.isCtrl = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== source/fetchPkg.sv ====
/*
 * Shared widths, opcodes and types for the second fetch stage.
 * Every fetch stage 2 module imports this package, and the testbench
 * uses the same structs to build stimulus and expected results.
 */
`default_nettype none

package fetchPkg;

  localparam int FETCH_WIDTH = 4;
  localparam int INST_BYTES  = 8;
  localparam int CTIQ_DEPTH  = 16;
  localparam int CTIQ_LOG    = $clog2(CTIQ_DEPTH);

  typedef logic [31:0]             pc_t;
  typedef logic [63:0]             inst_t;
  typedef logic [7:0]              opcode_t;
  typedef logic [CTIQ_LOG-1:0]     ctiTag_t;
  typedef logic [FETCH_WIDTH-1:0]  slotMask_t;
  typedef logic [$clog2(FETCH_WIDTH)-1:0] slotIdx_t;

  // opcode lives in bits 63:56
  localparam opcode_t OP_J   = 8'h02;
  localparam opcode_t OP_JAL = 8'h03;
  localparam opcode_t OP_BEQ = 8'h04;
  localparam opcode_t OP_BNE = 8'h05;
  localparam opcode_t OP_JR  = 8'h08;

  typedef enum logic [1:0] {
    ctrlReturn = 2'b00,
    ctrlCall   = 2'b01,
    ctrlJump   = 2'b10,
    ctrlCond   = 2'b11
  } ctrlType_t;

  typedef struct packed {
    logic hit;
    pc_t  target;
    logic prediction;
  } btbSlot_t;

  typedef struct packed {
    logic      isCtrl;
    ctrlType_t ctrlType;
    pc_t       target;
  } preDec_t;

  typedef struct packed {
    inst_t   instruction;
    pc_t     pc;
    pc_t     target;
    ctiTag_t ctiqTag;
    logic    prediction;
  } instPacket_t;

  // sent to the BTB and predictor when a CTI commits
  typedef struct packed {
    pc_t       pc;
    pc_t       target;
    ctrlType_t ctrlType;
    logic      taken;
  } ctiUpdate_t;

endpackage

`default_nettype wire
